/* verilog/sdram_pkg.sv */
//////////////////////////////
// SDRAM controller shared types: commands, states,
// request and pin structs, address split helpers
//////////////////////////////
`default_nettype none

package sdram_pkg;

  localparam int ADDR_W      = 24;
  localparam int DATA_W      = 16;
  localparam int ROW_W       = 13;
  localparam int COL_W       = 9;
  localparam int CAS_LATENCY = 2;

  localparam logic [ROW_W-1:0] MODE_WORD = 13'h020;  // CL2, burst of 1

  // {ras_n, cas_n, we_n}
  typedef enum logic [2:0] {
    CMD_LOAD_MODE = 3'h0,
    CMD_REFRESH   = 3'h1,
    CMD_PRECHARGE = 3'h2,
    CMD_ACTIVE    = 3'h3,
    CMD_WRITE     = 3'h4,
    CMD_READ      = 3'h5,
    CMD_NOP       = 3'h7
  } sdram_cmd_e;

  typedef enum logic [2:0] {
    AS_IDLE, AS_OPEN, AS_WAIT, AS_READ, AS_WRITE, AS_IDLE_OPEN, AS_PRECH, AS_REFRESH
  } access_state_e;

  typedef enum logic [2:0] {
    IS_WAIT_TIMER, IS_PRECH, IS_WAIT, IS_REFRESH, IS_MODE, IS_DONE
  } init_state_e;

  typedef struct packed {
    logic              rnw;
    logic [ADDR_W-1:0] addr;
    logic [1:0]        be_n;   // zero on reads
    logic [DATA_W-1:0] data;
  } sdram_req_t;

  typedef struct packed {
    logic             cs_n;
    sdram_cmd_e       cmd;
    logic [1:0]       ba;
    logic [ROW_W-1:0] addr;
    logic [1:0]       dqm;
  } sdram_pins_t;

  localparam sdram_pins_t PINS_IDLE = '{cs_n: 1'b1, cmd: CMD_NOP, ba: 2'b00,
                                        addr: '0, dqm: 2'b00};

  // bank sits on addr bits 23 and 9
  function automatic logic [1:0] addr_bank(input logic [ADDR_W-1:0] a);
    return {a[23], a[9]};
  endfunction

  function automatic logic [ROW_W-1:0] addr_row(input logic [ADDR_W-1:0] a);
    return a[22:10];
  endfunction

  function automatic logic [COL_W-1:0] addr_col(input logic [ADDR_W-1:0] a);
    return a[COL_W-1:0];
  endfunction

endpackage

`default_nettype wire

/* verilog/sdram_req_fifo.sv */
//////////////////////////////
// two-entry request FIFO with full and empty flags
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module sdram_req_fifo
  import sdram_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       i_push,
  input  sdram_req_t i_push_req,
  input  logic       i_pop,
  output sdram_req_t o_head,
  output logic       o_empty,
  output logic       o_full
);

  sdram_req_t entries [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       push_ok;
  logic       pop_ok;

  assign o_full  = (count == 2'd2);
  assign o_empty = (count == 2'd0);
  assign o_head  = entries[rd_ptr];

  assign push_ok = i_push && !o_full;
  assign pop_ok  = i_pop && !o_empty;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end
    else
    begin
      if (push_ok)
        wr_ptr <= ~wr_ptr;  // wraps at two
      if (pop_ok)
        rd_ptr <= ~rd_ptr;
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (push_ok)
      entries[wr_ptr] <= i_push_req;
  end

  // engine must only take a head that exists
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!reset_n)
    i_pop |-> !o_empty);

endmodule

`default_nettype wire

/* verilog/sdram_refresh_timer.sv */
//////////////////////////////
// power-up wait and periodic refresh countdown
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module sdram_refresh_timer #(
  parameter int INIT_WAIT      = 4800,
  parameter int REFRESH_PERIOD = 750
) (
  input  logic clk,
  input  logic reset_n,
  input  logic i_init_done,
  input  logic i_refresh_ack,
  output logic o_expire,
  output logic o_refresh_req
);

  localparam int MAX_CNT = (INIT_WAIT > REFRESH_PERIOD) ? INIT_WAIT : REFRESH_PERIOD;
  localparam int CNT_W   = $clog2(MAX_CNT + 1);

  logic [CNT_W-1:0] count;

  assign o_expire = (count == '0);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      count <= CNT_W'(INIT_WAIT);  // first pass is the power-up wait
    else if (o_expire)
      count <= CNT_W'(REFRESH_PERIOD - 1);
    else
      count <= count - 1'b1;
  end

  // held until the engine acks, never before init completes
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      o_refresh_req <= 1'b0;
    else
      o_refresh_req <= (o_expire || o_refresh_req) && !i_refresh_ack && i_init_done;
  end

  a_ack_needs_req: assert property (@(posedge clk) disable iff (!reset_n)
    i_refresh_ack |-> o_refresh_req);

endmodule

`default_nettype wire

/* verilog/sdram_init_seq.sv */
//////////////////////////////
// power-up command sequence: precharge-all,
// two auto-refreshes, mode register load
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module sdram_init_seq
  import sdram_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        i_expire,
  output sdram_pins_t o_pins,
  output logic        o_init_done
);

  init_state_e state;
  init_state_e ret_state;  // where to go after the NOP wait
  logic [2:0]  count;
  logic        ref_cnt;    // set after the first refresh

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state       <= IS_WAIT_TIMER;
      ret_state   <= IS_WAIT_TIMER;
      count       <= 3'd0;
      ref_cnt     <= 1'b0;
      o_pins      <= PINS_IDLE;
      o_init_done <= 1'b0;
    end
    else
    begin
      o_init_done <= o_init_done || (state == IS_DONE);
      o_pins.cs_n <= 1'b0;
      o_pins.cmd  <= CMD_NOP;
      o_pins.addr <= '1;  // A10 high for precharge-all
      case (state)
        IS_WAIT_TIMER:
        begin
          o_pins.cs_n <= 1'b1;  // bus inhibited during power-up wait
          ref_cnt     <= 1'b0;
          if (i_expire)
            state <= IS_PRECH;
        end
        IS_PRECH:
        begin
          o_pins.cmd <= CMD_PRECHARGE;
          count      <= 3'd0;
          ret_state  <= IS_REFRESH;
          state      <= IS_WAIT;
        end
        IS_WAIT:
        begin
          if (count > 3'd1)
            count <= count - 1'b1;
          else
            state <= ret_state;
        end
        IS_REFRESH:
        begin
          o_pins.cmd <= CMD_REFRESH;
          ref_cnt    <= 1'b1;
          count      <= 3'd3;  // tRFC
          ret_state  <= ref_cnt ? IS_MODE : IS_REFRESH;
          state      <= IS_WAIT;
        end
        IS_MODE:
        begin
          o_pins.cmd  <= CMD_LOAD_MODE;
          o_pins.addr <= MODE_WORD;
          count       <= 3'd4;
          ret_state   <= IS_DONE;
          state       <= IS_WAIT;
        end
        IS_DONE: state <= IS_DONE;
        default: state <= IS_WAIT_TIMER;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/sdram_access_fsm.sv */
//////////////////////////////
// row/column command engine with same-row
// streaming and refresh service
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module sdram_access_fsm
  import sdram_pkg::*;
(
  input  logic              clk,
  input  logic              reset_n,
  input  sdram_req_t        i_head,
  input  logic              i_empty,
  output logic              o_pop,
  input  logic              i_refresh_req,
  output logic              o_refresh_ack,
  input  sdram_pins_t       i_init_pins,
  input  logic              i_init_done,
  output sdram_pins_t       o_pins,
  output logic [DATA_W-1:0] o_wdata,
  output logic              o_oe
);

  access_state_e state;
  access_state_e ret_state;
  logic [2:0]    count;
  sdram_req_t    act;         // request being served
  logic          take_ok;
  logic          head_match;
  logic          row_active;  // a row opened since the last precharge

  assign take_ok = !i_empty && !i_refresh_req;

  // head may reuse the open row only for same bank, row and direction
  assign head_match = (addr_bank(i_head.addr) == addr_bank(act.addr))
                   && (addr_row(i_head.addr) == addr_row(act.addr))
                   && (i_head.rnw == act.rnw);

  always_comb
  begin
    o_pop = 1'b0;
    case (state)
      AS_IDLE:                         o_pop = take_ok && i_init_done;
      AS_READ, AS_WRITE, AS_IDLE_OPEN: o_pop = take_ok && head_match;
      default:                         o_pop = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (o_pop)
      act <= i_head;
  end

  always_ff @(posedge clk)
  begin
    if (state == AS_WRITE)
      o_wdata <= act.data;  // lines up with the WRITE command
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state         <= AS_IDLE;
      ret_state     <= AS_IDLE;
      count         <= 3'd0;
      o_pins        <= PINS_IDLE;
      o_oe          <= 1'b0;
      o_refresh_ack <= 1'b0;
    end
    else
    begin
      o_oe          <= 1'b0;
      o_refresh_ack <= 1'b0;
      o_pins.cs_n   <= 1'b0;
      o_pins.cmd    <= CMD_NOP;
      case (state)
        AS_IDLE:
        begin
          // all banks closed here
          if (!i_init_done)
            o_pins <= i_init_pins;  // init sequencer owns the bus
          else if (i_refresh_req)
            state <= AS_REFRESH;
          else if (!i_empty)
            state <= AS_OPEN;
        end
        AS_OPEN:
        begin
          o_pins.cmd  <= CMD_ACTIVE;
          o_pins.ba   <= addr_bank(act.addr);
          o_pins.addr <= addr_row(act.addr);
          count       <= 3'd1;  // tRCD
          ret_state   <= act.rnw ? AS_READ : AS_WRITE;
          state       <= AS_WAIT;
        end
        AS_WAIT:
        begin
          if (count > 3'd1)
            count <= count - 1'b1;
          else
            state <= ret_state;
        end
        AS_READ, AS_WRITE:
        begin
          o_pins.cmd  <= act.rnw ? CMD_READ : CMD_WRITE;
          o_pins.ba   <= addr_bank(act.addr);
          o_pins.addr <= ROW_W'(addr_col(act.addr));  // A10 low for no auto-precharge
          o_pins.dqm  <= act.be_n;
          o_oe        <= !act.rnw;
          if (!(take_ok && head_match))
            state <= AS_IDLE_OPEN;  // stream ends with the row left open
        end
        AS_IDLE_OPEN:
        begin
          if (i_refresh_req)
            state <= AS_PRECH;
          else if (!i_empty)
          begin
            if (head_match)
              state <= i_head.rnw ? AS_READ : AS_WRITE;
            else
              state <= AS_PRECH;
          end
        end
        AS_PRECH:
        begin
          o_pins.cmd  <= CMD_PRECHARGE;
          o_pins.addr <= '1;    // precharge all banks
          count       <= 3'd1;  // tRP
          ret_state   <= AS_IDLE;
          state       <= AS_WAIT;
        end
        AS_REFRESH:
        begin
          o_pins.cmd    <= CMD_REFRESH;
          o_refresh_ack <= 1'b1;
          count         <= 3'd3;  // recovery before next ACTIVE
          ret_state     <= AS_IDLE;
          state         <= AS_WAIT;
        end
        default: state <= AS_IDLE;
      endcase
    end
  end

  // follows the command stream on the pins
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      row_active <= 1'b0;
    else if (o_pins.cmd == CMD_ACTIVE)
      row_active <= 1'b1;
    else if (o_pins.cmd == CMD_PRECHARGE)
      row_active <= 1'b0;
  end

  // no column command between a precharge and the next ACTIVE
  a_active_before_col: assert property (@(posedge clk) disable iff (!reset_n)
    (o_pins.cmd inside {CMD_READ, CMD_WRITE}) |-> row_active);

endmodule

`default_nettype wire

/* verilog/sdram_dq_io.sv */
//////////////////////////////
// dq pad drive and CAS-latency read return
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module sdram_dq_io
  import sdram_pkg::*;
(
  input  logic              clk,
  input  logic              reset_n,
  input  sdram_pins_t       i_pins,
  input  logic [DATA_W-1:0] i_wdata,
  input  logic              i_oe,
  inout  wire  [DATA_W-1:0] io_dq,
  output logic [DATA_W-1:0] o_rdata,
  output logic              o_rvalid
);

  logic [CAS_LATENCY-1:0] rd_pipe;  // one bit per cycle of CAS latency
  logic                   rd_cmd;

  assign io_dq  = i_oe ? i_wdata : {DATA_W{1'bz}};
  assign rd_cmd = !i_pins.cs_n && (i_pins.cmd == CMD_READ);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      rd_pipe  <= '0;
      o_rvalid <= 1'b0;
    end
    else
    begin
      rd_pipe  <= {rd_pipe[CAS_LATENCY-2:0], rd_cmd};
      o_rvalid <= rd_pipe[CAS_LATENCY-1];  // matches capture below
    end
  end

  always_ff @(posedge clk)
  begin
    o_rdata <= io_dq;
  end

endmodule

`default_nettype wire

/* verilog/sdram_ctrl_top.sv */
//////////////////////////////
// SDR SDRAM controller top level
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module sdram_ctrl_top
  import sdram_pkg::*;
#(
  parameter int INIT_WAIT      = 4800,
  parameter int REFRESH_PERIOD = 750
) (
  input  logic              clk,
  input  logic              reset_n,
  input  logic [ADDR_W-1:0] i_addr,
  input  logic [1:0]        i_be_n,
  input  logic [DATA_W-1:0] i_wdata,
  input  logic              i_rd_n,
  input  logic              i_wr_n,
  output logic              o_waitrequest,
  output logic [DATA_W-1:0] o_rdata,
  output logic              o_rvalid,
  output logic [ROW_W-1:0]  o_sd_addr,
  output logic [1:0]        o_sd_ba,
  output logic              o_sd_cs_n,
  output logic              o_sd_ras_n,
  output logic              o_sd_cas_n,
  output logic              o_sd_we_n,
  output logic              o_sd_cke,
  output logic [1:0]        o_sd_dqm,
  inout  wire  [DATA_W-1:0] io_sd_dq
);

  sdram_req_t        push_req;
  sdram_req_t        head;
  sdram_pins_t       init_pins;
  sdram_pins_t       pins;
  logic              push;
  logic              pop;
  logic              empty;
  logic              expire;
  logic              init_done;
  logic              refresh_req;
  logic              refresh_ack;
  logic              oe;
  logic [DATA_W-1:0] wdata;

  assign push     = (!i_rd_n || !i_wr_n) && !o_waitrequest;
  assign push_req = '{rnw: i_wr_n, addr: i_addr, be_n: (i_wr_n ? 2'b00 : i_be_n),
                      data: i_wdata};

  sdram_req_fifo req_fifo_i (
    .clk(clk), .reset_n(reset_n),
    .i_push(push), .i_push_req(push_req), .i_pop(pop),
    .o_head(head), .o_empty(empty), .o_full(o_waitrequest)
  );

  sdram_refresh_timer #(
    .INIT_WAIT(INIT_WAIT), .REFRESH_PERIOD(REFRESH_PERIOD)
  ) refresh_timer_i (
    .clk(clk), .reset_n(reset_n),
    .i_init_done(init_done), .i_refresh_ack(refresh_ack),
    .o_expire(expire), .o_refresh_req(refresh_req)
  );

  sdram_init_seq init_seq_i (
    .clk(clk), .reset_n(reset_n),
    .i_expire(expire), .o_pins(init_pins), .o_init_done(init_done)
  );

  sdram_access_fsm access_fsm_i (
    .clk(clk), .reset_n(reset_n),
    .i_head(head), .i_empty(empty), .o_pop(pop),
    .i_refresh_req(refresh_req), .o_refresh_ack(refresh_ack),
    .i_init_pins(init_pins), .i_init_done(init_done),
    .o_pins(pins), .o_wdata(wdata), .o_oe(oe)
  );

  sdram_dq_io dq_io_i (
    .clk(clk), .reset_n(reset_n),
    .i_pins(pins), .i_wdata(wdata), .i_oe(oe),
    .io_dq(io_sd_dq), .o_rdata(o_rdata), .o_rvalid(o_rvalid)
  );

  // pin struct onto the device pins
  assign o_sd_cs_n                            = pins.cs_n;
  assign {o_sd_ras_n, o_sd_cas_n, o_sd_we_n} = pins.cmd;
  assign o_sd_ba                              = pins.ba;
  assign o_sd_addr                            = pins.addr;
  assign o_sd_dqm                             = pins.dqm;
  assign o_sd_cke                             = 1'b1;  // no power-down

endmodule

`default_nettype wire

/* bench/sdram_model.sv */
//////////////////////////////
// behavioral SDRAM: command decode,
// byte-masked storage, init order check
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module sdram_model
  import sdram_pkg::*;
(
  input  logic              clk,
  input  logic              reset_n,
  input  logic              i_cs_n,
  input  logic              i_ras_n,
  input  logic              i_cas_n,
  input  logic              i_we_n,
  input  logic [1:0]        i_ba,
  input  logic [ROW_W-1:0]  i_addr,
  input  logic [1:0]        i_dqm,
  inout  wire  [DATA_W-1:0] io_dq,
  output logic [15:0]       o_errors,
  output logic [15:0]       o_refresh_cnt,
  output logic              o_init_ok
);

  logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
  logic [ROW_W-1:0]  open_row [4];
  logic [3:0]        row_open;
  logic [2:0]        init_step;  // init commands seen in order
  logic [DATA_W:0]   rd_stage0;  // {valid, data}, one per CAS cycle
  logic [DATA_W:0]   rd_stage1;
  sdram_cmd_e        cmd;
  logic [ADDR_W-1:0] key;

  assign cmd       = sdram_cmd_e'({i_ras_n, i_cas_n, i_we_n});
  assign key       = {i_ba, open_row[i_ba], i_addr[COL_W-1:0]};
  assign o_init_ok = (init_step == 3'd4);
  assign io_dq     = rd_stage1[DATA_W] ? rd_stage1[DATA_W-1:0] : {DATA_W{1'bz}};

  always @(posedge clk or negedge reset_n)
  begin : decode
    logic              err;
    logic [DATA_W-1:0] word;
    err  = 1'b0;
    word = '0;
    if (!reset_n)
    begin
      row_open      <= 4'b0000;
      init_step     <= 3'd0;
      rd_stage0     <= '0;
      rd_stage1     <= '0;
      o_errors      <= 16'd0;
      o_refresh_cnt <= 16'd0;
    end
    else
    begin
      rd_stage1 <= rd_stage0;
      rd_stage0 <= '0;
      if (!i_cs_n)
      begin
        case (cmd)
          CMD_PRECHARGE:
          begin
            if (i_addr[10])
              row_open <= 4'b0000;  // all banks
            else
              row_open[i_ba] <= 1'b0;
            if (init_step == 3'd0 && i_addr[10])
              init_step <= 3'd1;
            else if (init_step == 3'd0)
            begin
              $display("model: first precharge does not close all banks");
              err = 1'b1;
            end
          end
          CMD_REFRESH:
          begin
            o_refresh_cnt <= o_refresh_cnt + 16'd1;
            if (init_step == 3'd1 || init_step == 3'd2)
              init_step <= init_step + 3'd1;
            else if (init_step != 3'd4)
            begin
              $display("model: refresh out of order in the init sequence");
              err = 1'b1;
            end
          end
          CMD_LOAD_MODE:
          begin
            if (init_step != 3'd3 || i_addr != MODE_WORD)
            begin
              $display("model: mode load 0x%03h out of order or wrong value", i_addr);
              err = 1'b1;
            end
            else
              init_step <= 3'd4;
          end
          CMD_ACTIVE:
          begin
            if (init_step != 3'd4)
            begin
              $display("model: ACTIVE issued before the init sequence ended");
              err = 1'b1;
            end
            row_open[i_ba] <= 1'b1;
            open_row[i_ba] <= i_addr;
          end
          CMD_WRITE, CMD_READ:
          begin
            if (!row_open[i_ba])
            begin
              $display("model: column command to closed bank %0d", i_ba);
              err = 1'b1;
            end
            else
            begin
              word = (mem.exists(key) != 0) ? mem[key] : 16'h0000;
              if (cmd == CMD_READ)
                rd_stage0 <= {1'b1, word};
              else
              begin
                if (!i_dqm[0])
                  word[7:0] = io_dq[7:0];
                if (!i_dqm[1])
                  word[15:8] = io_dq[15:8];
                mem[key] = word;
              end
            end
          end
          default: ;
        endcase
      end
      if (err)
        o_errors <= o_errors + 16'd1;
    end
  end

endmodule

`default_nettype wire

/* bench/tb_sdram_ctrl.sv */
//////////////////////////////
// testbench for the SDRAM controller with step table,
// shadow memory, read order check and watchdog
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_sdram_ctrl
  import sdram_pkg::*;
();

  localparam int NUM_STEPS = 32;
  localparam int NUM_TESTS = 6;
  localparam int WATCHDOG_CYCLES = NUM_STEPS * 200 + 2000;

  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_IDLE} op_e;

  typedef struct packed {
    logic [2:0]        test_id;
    op_e               op;
    logic [ADDR_W-1:0] addr;
    logic [1:0]        be_n;
    logic              use_lfsr;
    logic [DATA_W-1:0] data;  // literal data or cycles for an idle step
  } step_t;

  typedef struct packed {
    logic [2:0]        test_id;
    logic [DATA_W-1:0] data;
  } expect_t;

  logic              clk = 1'b0;
  logic              reset_n;
  logic [ADDR_W-1:0] i_addr;
  logic [1:0]        i_be_n;
  logic [DATA_W-1:0] i_wdata;
  logic              i_rd_n;
  logic              i_wr_n;
  logic              o_waitrequest;
  logic [DATA_W-1:0] o_rdata;
  logic              o_rvalid;
  logic [ROW_W-1:0]  sd_addr;
  logic [1:0]        sd_ba;
  logic              sd_cs_n;
  logic              sd_ras_n;
  logic              sd_cas_n;
  logic              sd_we_n;
  logic              sd_cke;
  logic [1:0]        sd_dqm;
  wire  [DATA_W-1:0] sd_dq;
  logic [15:0]       model_errors;
  logic [15:0]       refresh_cnt;
  logic              init_ok;

  step_t             steps [NUM_STEPS];
  string             test_names [NUM_TESTS];
  int                checks [NUM_TESTS];
  int                errs [NUM_TESTS];
  int                total_checks;
  int                total_errors;
  logic [15:0]       lfsr_state;
  logic [DATA_W-1:0] shadow [logic [ADDR_W-1:0]];
  expect_t           exp_q [$];
  expect_t           rd_head;

  always #5 clk = ~clk;

  sdram_ctrl_top #(.INIT_WAIT(40), .REFRESH_PERIOD(100)) dut_i (
    .clk(clk), .reset_n(reset_n),
    .i_addr(i_addr), .i_be_n(i_be_n), .i_wdata(i_wdata), .i_rd_n(i_rd_n), .i_wr_n(i_wr_n),
    .o_waitrequest(o_waitrequest), .o_rdata(o_rdata), .o_rvalid(o_rvalid),
    .o_sd_addr(sd_addr), .o_sd_ba(sd_ba), .o_sd_cs_n(sd_cs_n), .o_sd_ras_n(sd_ras_n),
    .o_sd_cas_n(sd_cas_n), .o_sd_we_n(sd_we_n), .o_sd_cke(sd_cke), .o_sd_dqm(sd_dqm),
    .io_sd_dq(sd_dq)
  );

  sdram_model model_i (
    .clk(clk), .reset_n(reset_n),
    .i_cs_n(sd_cs_n), .i_ras_n(sd_ras_n), .i_cas_n(sd_cas_n), .i_we_n(sd_we_n),
    .i_ba(sd_ba), .i_addr(sd_addr), .i_dqm(sd_dqm), .io_dq(sd_dq),
    .o_errors(model_errors), .o_refresh_cnt(refresh_cnt), .o_init_ok(init_ok)
  );

  function automatic step_t make_step(input logic [2:0] id, input op_e op,
                                      input logic [ADDR_W-1:0] addr, input logic [1:0] be_n,
                                      input logic use_lfsr, input logic [DATA_W-1:0] data);
    step_t s;
    s.test_id  = id;
    s.op       = op;
    s.addr     = addr;
    s.be_n     = be_n;
    s.use_lfsr = use_lfsr;
    s.data     = data;
    return s;
  endfunction

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic lfsr_word(output logic [DATA_W-1:0] w);
    w = '0;
    for (int b = 0; b < DATA_W; b++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[DATA_W-2:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input int id, input logic [15:0] expected,
                             input logic [15:0] actual);
    checks[id]++;
    total_checks++;
    if (expected !== actual)
    begin
      errs[id]++;
      total_errors++;
      $display("Fail %s: expected 0x%04h, actual 0x%04h", test_names[id], expected, actual);
    end
  endtask

  task automatic fill_table();
    steps[0]  = make_step(3'd1, OP_WRITE, 24'h000100, 2'b00, 1'b0, 16'hA5C3);
    steps[1]  = make_step(3'd1, OP_READ,  24'h000100, 2'b00, 1'b0, 16'h0000);
    steps[2]  = make_step(3'd1, OP_WRITE, 24'h800205, 2'b00, 1'b0, 16'h1234);
    steps[3]  = make_step(3'd1, OP_READ,  24'h800205, 2'b00, 1'b0, 16'h0000);
    steps[4]  = make_step(3'd2, OP_WRITE, 24'h000101, 2'b00, 1'b0, 16'hFFFF);
    steps[5]  = make_step(3'd2, OP_WRITE, 24'h000101, 2'b10, 1'b0, 16'h0012);  // low byte only
    steps[6]  = make_step(3'd2, OP_READ,  24'h000101, 2'b00, 1'b0, 16'h0000);
    steps[7]  = make_step(3'd2, OP_WRITE, 24'h000101, 2'b01, 1'b0, 16'h5600);  // high byte only
    steps[8]  = make_step(3'd2, OP_READ,  24'h000101, 2'b00, 1'b0, 16'h0000);
    steps[9]  = make_step(3'd3, OP_WRITE, 24'h000010, 2'b00, 1'b1, 16'h0000);
    steps[10] = make_step(3'd3, OP_WRITE, 24'h000011, 2'b00, 1'b1, 16'h0000);
    steps[11] = make_step(3'd3, OP_WRITE, 24'h000012, 2'b00, 1'b1, 16'h0000);
    steps[12] = make_step(3'd3, OP_READ,  24'h000010, 2'b00, 1'b0, 16'h0000);
    steps[13] = make_step(3'd3, OP_READ,  24'h000011, 2'b00, 1'b0, 16'h0000);
    steps[14] = make_step(3'd3, OP_READ,  24'h000012, 2'b00, 1'b0, 16'h0000);
    steps[15] = make_step(3'd3, OP_WRITE, 24'h400210, 2'b00, 1'b1, 16'h0000);  // bank 1
    steps[16] = make_step(3'd3, OP_WRITE, 24'h800013, 2'b00, 1'b1, 16'h0000);  // bank 2
    steps[17] = make_step(3'd3, OP_READ,  24'h400210, 2'b00, 1'b0, 16'h0000);
    steps[18] = make_step(3'd3, OP_WRITE, 24'h000413, 2'b00, 1'b1, 16'h0000);  // row 1
    steps[19] = make_step(3'd3, OP_READ,  24'h000413, 2'b00, 1'b0, 16'h0000);
    steps[20] = make_step(3'd3, OP_READ,  24'h800013, 2'b00, 1'b0, 16'h0000);
    steps[21] = make_step(3'd3, OP_WRITE, 24'h000014, 2'b00, 1'b1, 16'h0000);
    steps[22] = make_step(3'd3, OP_WRITE, 24'h000015, 2'b00, 1'b1, 16'h0000);
    steps[23] = make_step(3'd3, OP_READ,  24'h000014, 2'b00, 1'b0, 16'h0000);
    steps[24] = make_step(3'd3, OP_READ,  24'h000015, 2'b00, 1'b0, 16'h0000);
    steps[25] = make_step(3'd3, OP_READ,  24'h000011, 2'b00, 1'b0, 16'h0000);
    steps[26] = make_step(3'd4, OP_IDLE,  24'h000000, 2'b00, 1'b0, 16'd1000);
    steps[27] = make_step(3'd4, OP_READ,  24'h000100, 2'b00, 1'b0, 16'h0000);
    steps[28] = make_step(3'd4, OP_READ,  24'h000101, 2'b00, 1'b0, 16'h0000);
    steps[29] = make_step(3'd4, OP_READ,  24'h800205, 2'b00, 1'b0, 16'h0000);
    steps[30] = make_step(3'd4, OP_READ,  24'h400210, 2'b00, 1'b0, 16'h0000);
    steps[31] = make_step(3'd4, OP_READ,  24'h000012, 2'b00, 1'b0, 16'h0000);
  endtask

  task automatic release_bus();
    @(negedge clk);
    i_rd_n = 1'b1;
    i_wr_n = 1'b1;
  endtask

  task automatic drain_reads();
    while (exp_q.size() != 0)
      @(negedge clk);
  endtask

  task automatic report_test(input int id);
    $display("test %-14s %0d checks, %0d errors", test_names[id], checks[id], errs[id]);
  endtask

  task automatic finish_test(input int id);
    release_bus();
    drain_reads();
    report_test(id);
  endtask

  task automatic apply_step(input step_t s);
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] merged;
    logic [15:0]       ref_start;
    expect_t           e;
    data = s.data;
    if (s.op == OP_IDLE)
    begin
      release_bus();
      drain_reads();
      ref_start = refresh_cnt;
      repeat (int'(s.data)) @(negedge clk);
      check_value(int'(s.test_id), 16'd1, ((refresh_cnt - ref_start) >= 16'd9) ? 16'd1 : 16'd0);
      return;
    end
    if (s.use_lfsr)
      lfsr_word(data);
    @(negedge clk);
    i_addr  = s.addr;
    i_be_n  = (s.op == OP_WRITE) ? s.be_n : 2'b00;
    i_wdata = data;
    i_wr_n  = (s.op != OP_WRITE);
    i_rd_n  = (s.op != OP_READ);
    merged  = (shadow.exists(s.addr) != 0) ? shadow[s.addr] : 16'h0000;
    if (s.op == OP_WRITE)
    begin
      if (!s.be_n[0])
        merged[7:0] = data[7:0];
      if (!s.be_n[1])
        merged[15:8] = data[15:8];
      shadow[s.addr] = merged;
    end
    else
    begin
      e.test_id = s.test_id;
      e.data    = merged;
      exp_q.push_back(e);
    end
    while (o_waitrequest)
      @(negedge clk);  // hold until the FIFO has room
  endtask

  // reads come back in request order
  always @(negedge clk)
  begin
    if (reset_n && o_rvalid)
    begin
      if (exp_q.size() == 0)
      begin
        $display("read data 0x%04h returned with no read outstanding", o_rdata);
        total_errors++;
      end
      else
      begin
        rd_head = exp_q.pop_front();
        check_value(int'(rd_head.test_id), rd_head.data, o_rdata);
      end
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles, %0d reads outstanding", WATCHDOG_CYCLES,
             exp_q.size());
    $display("Result: FAILED");
    $finish;
  end

  initial
  begin
    int cur_id;
    test_names[0] = "init_order";
    test_names[1] = "write_read";
    test_names[2] = "byte_mask";
    test_names[3] = "mixed_traffic";
    test_names[4] = "refresh";
    test_names[5] = "protocol";
    reset_n      = 1'b0;
    i_addr       = '0;
    i_be_n       = 2'b00;
    i_wdata      = '0;
    i_rd_n       = 1'b1;
    i_wr_n       = 1'b1;
    lfsr_state   = 16'd24;
    total_checks = 0;
    total_errors = 0;
    fill_table();
    repeat (10) @(posedge clk);
    @(negedge clk);
    check_value(0, 16'd1, {15'd0, sd_cs_n});  // bus deselected in reset
    check_value(0, 16'd0, {14'd0, o_waitrequest, o_rvalid});
    reset_n = 1'b1;
    for (int n = 0; n < 200 && !init_ok; n++)
      @(negedge clk);
    check_value(0, 16'd1, {15'd0, init_ok});
    check_value(0, 16'd0, model_errors);
    report_test(0);
    cur_id = 1;
    for (int i = 0; i < NUM_STEPS; i++)
    begin
      if (int'(steps[i].test_id) != cur_id)
      begin
        finish_test(cur_id);
        cur_id = int'(steps[i].test_id);
      end
      apply_step(steps[i]);
    end
    finish_test(cur_id);
    check_value(5, 16'd0, model_errors);
    check_value(5, 16'd1, {15'd0, sd_cke});
    report_test(5);
    $display("checks: %0d, errors: %0d", total_checks, total_errors);
    if (total_errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
verilog/sdram_pkg.sv
verilog/sdram_req_fifo.sv
verilog/sdram_refresh_timer.sv
verilog/sdram_init_seq.sv
verilog/sdram_access_fsm.sv
verilog/sdram_dq_io.sv
verilog/sdram_ctrl_top.sv
bench/sdram_model.sv
bench/tb_sdram_ctrl.sv

/* Makefile */
TOP = tb_sdram_ctrl

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert -j 0 --top-module $(TOP) -f sources.f -Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
